/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD_SIZE 16
`define NUM_REGS 4

// opcodes, upper 4 bits of the instruction word
`define BNE_OP 4'd0
`define BEQ_OP 4'd1
`define ADI_OP 4'd4
`define ORI_OP 4'd5
`define LHI_OP 4'd6
`define JMP_OP 4'd9
`define JPR_OP 4'd11
`define ALU_OP 4'd15

// function codes under ALU_OP
`define INST_FUNC_ADD 6'd0
`define INST_FUNC_SUB 6'd1
`define INST_FUNC_AND 6'd2
`define INST_FUNC_ORR 6'd3
`define INST_FUNC_NOT 6'd4
`define INST_FUNC_TCP 6'd5
`define INST_FUNC_SHL 6'd6
`define INST_FUNC_SHR 6'd7
`define INST_FUNC_WWD 6'd28
`define INST_FUNC_HALT 6'd29

`define HS_TIMEOUT 2000 // cycles per handshake wait

`endif

/* verilog/cpu_pkg.sv */
`include "cpu_params.svh"

package cpu_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;

	// register format: ALU ops, WWD, HALT
	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [5:0] func;
	} rFmt_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [7:0] imm;
	} iFmt_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [11:0] target;
	} jFmt_t;

	// one fetched word, read by whichever format the opcode calls for
	typedef union packed {
		rFmt_t rFmt;
		iFmt_t iFmt;
		jFmt_t jFmt;
	} instr_t;

	typedef enum logic [2:0] {
		AluAdd, AluSub, AluAnd, AluOrr, AluNot, AluTcp, AluShl, AluShr
	} aluOp_t;

	typedef enum logic [1:0] {PcNext, PcBranch, PcJump, PcReg} pcSrc_t;

endpackage

/* verilog/fetchPort.sv */
`timescale 1ns/1ps

module fetchPort (
	input logic clk,
	input logic rstN,
	input logic fetchStart,
	input cpu_pkg::word_t pc,
	input logic imemAck,
	input cpu_pkg::word_t imemData,
	output logic imemReq,
	output cpu_pkg::word_t imemAddr,
	output logic instrValid,
	output cpu_pkg::instr_t instr
);

	localparam logic [1:0] StIdle = 2'd0;
	localparam logic [1:0] StWaitHigh = 2'd1;
	localparam logic [1:0] StWaitLow = 2'd2;

	logic [1:0] state;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= StIdle;
			imemReq <= 1'b0;
			instrValid <= 1'b0;
		end else begin
			instrValid <= 1'b0;
			case (state)
				StIdle: if (fetchStart) begin
					imemReq <= 1'b1;
					state <= StWaitHigh;
				end
				StWaitHigh: if (imemAck) begin
					imemReq <= 1'b0; // word is latched in the same edge
					state <= StWaitLow;
				end
				StWaitLow: if (!imemAck) begin
					instrValid <= 1'b1;
					state <= StIdle;
				end
				default: state <= StIdle;
			endcase
		end
	end

	// address and instruction word
	always_ff @(posedge clk) begin
		if (state == StIdle && fetchStart)
			imemAddr <= pc;
		if (state == StWaitHigh && imemAck)
			instr <= imemData;
	end

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module controlUnit (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input cpu_pkg::instr_t instr,
	input logic outDone,
	output logic fetchStart,
	output logic execEn,
	output logic regWrite,
	output logic aluSrcB,
	output cpu_pkg::aluOp_t aluOp,
	output cpu_pkg::pcSrc_t pcSrc,
	output logic branchNe,
	output logic isLhi,
	output logic wwdStart,
	output logic halted
);
	import cpu_pkg::*;

	localparam logic [2:0] StFetch = 3'd0;
	localparam logic [2:0] StWait = 3'd1;
	localparam logic [2:0] StExec = 3'd2;
	localparam logic [2:0] StOut = 3'd3;
	localparam logic [2:0] StHalt = 3'd4;

	logic [2:0] state;
	logic [2:0] nextState;
	logic [3:0] opcode;
	logic [5:0] func;
	logic decRegWrite;
	logic decAluSrcB;
	logic decBranchNe;
	logic decIsLhi;
	logic isWwd;
	logic isHalt;
	logic inExec;
	aluOp_t decAluOp;
	pcSrc_t decPcSrc;

	assign opcode = instr.rFmt.opcode;
	assign func = instr.rFmt.func;

	// unknown opcodes and func codes fall through as no-ops
	always_comb begin
		decRegWrite = 1'b0;
		decAluSrcB = 1'b0;
		decAluOp = AluAdd;
		decPcSrc = PcNext;
		decBranchNe = 1'b0;
		decIsLhi = 1'b0;
		isWwd = 1'b0;
		isHalt = 1'b0;
		case (opcode)
			`ALU_OP: begin
				decRegWrite = 1'b1;
				case (func)
					`INST_FUNC_ADD: decAluOp = AluAdd;
					`INST_FUNC_SUB: decAluOp = AluSub;
					`INST_FUNC_AND: decAluOp = AluAnd;
					`INST_FUNC_ORR: decAluOp = AluOrr;
					`INST_FUNC_NOT: decAluOp = AluNot;
					`INST_FUNC_TCP: decAluOp = AluTcp;
					`INST_FUNC_SHL: decAluOp = AluShl;
					`INST_FUNC_SHR: decAluOp = AluShr;
					`INST_FUNC_WWD: begin
						decRegWrite = 1'b0;
						isWwd = 1'b1;
					end
					`INST_FUNC_HALT: begin
						decRegWrite = 1'b0;
						isHalt = 1'b1;
					end
					default: decRegWrite = 1'b0;
				endcase
			end
			`ADI_OP: begin
				decRegWrite = 1'b1;
				decAluSrcB = 1'b1;
				decAluOp = AluAdd;
			end
			`ORI_OP: begin
				decRegWrite = 1'b1;
				decAluSrcB = 1'b1;
				decAluOp = AluOrr;
			end
			`LHI_OP: begin
				decRegWrite = 1'b1;
				decAluSrcB = 1'b1; // rt is the destination
				decIsLhi = 1'b1;
			end
			`BNE_OP: begin
				decPcSrc = PcBranch;
				decBranchNe = 1'b1;
			end
			`BEQ_OP: decPcSrc = PcBranch;
			`JMP_OP: decPcSrc = PcJump;
			`JPR_OP: decPcSrc = PcReg;
			default: ;
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			StFetch: nextState = StWait;
			StWait: if (instrValid) nextState = StExec;
			StExec: begin
				if (isHalt)
					nextState = StHalt;
				else if (isWwd)
					nextState = StOut;
				else
					nextState = StFetch;
			end
			StOut: if (outDone) nextState = StFetch;
			StHalt: nextState = StHalt; // only reset leaves
			default: nextState = StFetch;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= StFetch;
		else
			state <= nextState;
	end

	assign inExec = (state == StExec);
	assign fetchStart = (state == StFetch);
	assign execEn = inExec && !isHalt; // pc stays on the HALT word
	assign regWrite = inExec && decRegWrite;
	assign aluSrcB = inExec && decAluSrcB;
	assign aluOp = inExec ? decAluOp : AluAdd;
	assign pcSrc = inExec ? decPcSrc : PcNext;
	assign branchNe = inExec && decBranchNe;
	assign isLhi = inExec && decIsLhi;
	assign wwdStart = inExec && isWwd;
	assign halted = (state == StHalt);

endmodule

/* verilog/dataPath.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module dataPath (
	input logic clk,
	input logic rstN,
	input logic execEn,
	input logic regWrite,
	input logic aluSrcB,
	input cpu_pkg::aluOp_t aluOp,
	input cpu_pkg::pcSrc_t pcSrc,
	input logic branchNe,
	input logic isLhi,
	input cpu_pkg::instr_t instr,
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t rsValue
);
	import cpu_pkg::*;

	word_t regFile [`NUM_REGS];

	logic [1:0] rsIdx;
	logic [1:0] rtIdx;
	logic [1:0] rdIdx;
	logic [1:0] destIdx;
	logic [7:0] imm;
	word_t rsVal;
	word_t rtVal;
	word_t immSext;
	word_t immZext;
	word_t immExt;
	word_t operandB;
	word_t aluResult;
	word_t writeData;
	word_t pcPlus1;
	word_t branchTarget;
	word_t nextPc;
	logic regsEqual;
	logic branchTaken;

	assign rsIdx = instr.rFmt.rs;
	assign rtIdx = instr.rFmt.rt;
	assign rdIdx = instr.rFmt.rd;
	assign imm = instr.iFmt.imm;

	assign rsVal = regFile[rsIdx];
	assign rtVal = regFile[rtIdx];
	assign rsValue = rsVal; // WWD source

	assign immSext = {{8{imm[7]}}, imm};
	assign immZext = {8'h00, imm};
	// ORI is the only immediate op that zero-extends
	assign immExt = (aluOp == AluOrr) ? immZext : immSext;
	assign operandB = aluSrcB ? immExt : rtVal;

	always_comb begin
		case (aluOp)
			AluAdd: aluResult = rsVal + operandB;
			AluSub: aluResult = rsVal - operandB;
			AluAnd: aluResult = rsVal & operandB;
			AluOrr: aluResult = rsVal | operandB;
			AluNot: aluResult = ~rsVal;
			AluTcp: aluResult = ~rsVal + 16'd1;
			AluShl: aluResult = {rsVal[14:0], 1'b0};
			AluShr: aluResult = {rsVal[15], rsVal[15:1]}; // arithmetic shift
			default: aluResult = rsVal;
		endcase
	end

	assign writeData = isLhi ? {imm, 8'h00} : aluResult;
	assign destIdx = aluSrcB ? rtIdx : rdIdx; // immediate formats write rt

	assign pcPlus1 = pc + 16'd1;
	assign branchTarget = pcPlus1 + immSext;
	assign regsEqual = (rsVal == rtVal);
	assign branchTaken = branchNe ? !regsEqual : regsEqual;

	always_comb begin
		case (pcSrc)
			PcNext: nextPc = pcPlus1;
			PcBranch: nextPc = branchTaken ? branchTarget : pcPlus1;
			PcJump: nextPc = {pc[15:12], instr.jFmt.target};
			PcReg: nextPc = rsVal;
			default: nextPc = pcPlus1;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			for (int i = 0; i < `NUM_REGS; i++)
				regFile[i] <= '0;
		end else if (execEn) begin
			pc <= nextPc;
			if (regWrite)
				regFile[destIdx] <= writeData;
		end
	end

endmodule

/* verilog/outputPort.sv */
`timescale 1ns/1ps

module outputPort (
	input logic clk,
	input logic rstN,
	input logic wwdStart,
	input cpu_pkg::word_t rsValue,
	input logic outAck,
	output logic outReq,
	output cpu_pkg::word_t outData,
	output logic outDone
);

	localparam logic [1:0] StIdle = 2'd0;
	localparam logic [1:0] StWaitHigh = 2'd1;
	localparam logic [1:0] StWaitLow = 2'd2;

	logic [1:0] state;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= StIdle;
			outReq <= 1'b0;
			outDone <= 1'b0;
		end else begin
			outDone <= 1'b0;
			case (state)
				StIdle: if (wwdStart) begin
					outReq <= 1'b1;
					state <= StWaitHigh;
				end
				StWaitHigh: if (outAck) begin
					outReq <= 1'b0;
					state <= StWaitLow;
				end
				StWaitLow: if (!outAck) begin
					outDone <= 1'b1; // link idle again
					state <= StIdle;
				end
				default: state <= StIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
		if (state == StIdle && wwdStart)
			outData <= rsValue;

endmodule

/* verilog/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
	input logic clk,
	input logic rstN,
	input logic imemAck,
	input cpu_pkg::word_t imemData,
	input logic outAck,
	output logic imemReq,
	output cpu_pkg::word_t imemAddr,
	output logic outReq,
	output cpu_pkg::word_t outData,
	output logic halted
);
	import cpu_pkg::*;

	logic fetchStart;
	logic instrValid;
	logic execEn;
	logic regWrite;
	logic aluSrcB;
	logic branchNe;
	logic isLhi;
	logic wwdStart;
	logic outDone;
	aluOp_t aluOp;
	pcSrc_t pcSrc;
	instr_t instr;
	word_t pc;
	word_t rsValue;

	fetchPort fetchPort_inst (.clk, .rstN, .fetchStart, .pc, .imemAck, .imemData,
		.imemReq, .imemAddr, .instrValid, .instr);

	controlUnit controlUnit_inst (.clk, .rstN, .instrValid, .instr, .outDone,
		.fetchStart, .execEn, .regWrite, .aluSrcB, .aluOp, .pcSrc, .branchNe, .isLhi,
		.wwdStart, .halted);

	dataPath dataPath_inst (.clk, .rstN, .execEn, .regWrite, .aluSrcB, .aluOp,
		.pcSrc, .branchNe, .isLhi, .instr, .pc, .rsValue);

	outputPort outputPort_inst (.clk, .rstN, .wwdStart, .rsValue, .outAck,
		.outReq, .outData, .outDone);

endmodule

/* test/cpuTop_chk.sv */
`timescale 1ns/1ps

module cpuTop_chk (
	input logic clk,
	input logic rstN,
	input logic imemReq,
	input logic imemAck,
	input cpu_pkg::word_t imemAddr,
	input logic outReq,
	input logic outAck,
	input cpu_pkg::word_t outData,
	input logic halted
);

	int failCount = 0; // failed assertions so far

	imemAddrStable: assert property (@(posedge clk) disable iff (!rstN)
		(imemReq && $past(imemReq)) |-> $stable(imemAddr))
	else begin
		failCount++;
		$error("imemAddr changed while imemReq was high");
	end

	outDataStable: assert property (@(posedge clk) disable iff (!rstN)
		(outReq && $past(outReq)) |-> $stable(outData))
	else begin
		failCount++;
		$error("outData changed while outReq was high");
	end

	imemReqRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(imemReq) |-> !imemAck)
	else begin
		failCount++;
		$error("imemReq rose while imemAck was still high");
	end

	outReqRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> !outAck)
	else begin
		failCount++;
		$error("outReq rose while outAck was still high");
	end

	// only reset leaves the halt state
	haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
	else begin
		failCount++;
		$error("halted fell without a reset");
	end

endmodule

bind cpuTop cpuTop_chk cpuTop_chk_inst (.clk(clk), .rstN(rstN), .imemReq(imemReq),
	.imemAck(imemAck), .imemAddr(imemAddr), .outReq(outReq), .outAck(outAck),
	.outData(outData), .halted(halted));

/* test/cpuTop_tb.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpuTop_tb;
	import cpu_pkg::*;

	localparam logic [8:0] InfoBase = 9'h100; // program length, then expected count
	localparam logic [8:0] ExpBase = 9'h102;
	localparam int QuietCycles = 200;

	logic clk = 1'b0;
	logic rstN;
	logic imemAck;
	logic outAck;
	logic imemReq;
	logic outReq;
	logic halted;
	word_t imemData;
	word_t imemAddr;
	word_t outData;

	word_t caseMem [0:511];
	word_t expWords [$];
	word_t progLen;
	int outCount = 0;

	cpuTop cpuTop_inst (.clk, .rstN, .imemAck, .imemData, .outAck, .imemReq, .imemAddr,
		.outReq, .outData, .halted);

	always #4 clk = ~clk;

	always @(negedge clk)
		if (cpuTop_inst.cpuTop_chk_inst.failCount != 0)
			stopOnError("a handshake or halt assertion failed");

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input word_t actual, input word_t expected);
		if (actual !== expected)
			stopOnError($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			stopOnError($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
	endtask

	// one instruction fetch, ack raised 0 to 3 cycles after req
	task automatic serveFetch(output logic stopped);
		int waitCount;
		int delay;
		word_t addr;
		waitCount = 0;
		do begin
			@(negedge clk);
			waitCount++;
			if (waitCount > `HS_TIMEOUT)
				stopOnError("timeout: no instruction fetch request arrived");
		end while (!imemReq && !halted);
		stopped = halted;
		if (stopped)
			return;
		addr = imemAddr;
		if (addr >= progLen)
			stopOnError($sformatf("fetch from address %h lies outside the program", addr));
		delay = int'($urandom_range(3, 0));
		repeat (delay) @(negedge clk);
		@(posedge clk);
		imemData <= caseMem[addr[8:0]];
		imemAck <= 1'b1;
		waitCount = 0;
		do begin
			@(negedge clk);
			waitCount++;
			if (waitCount > `HS_TIMEOUT)
				stopOnError("timeout: imemReq stayed high after the ack");
		end while (imemReq);
		@(posedge clk);
		imemAck <= 1'b0;
	endtask

	// one WWD word taken in, ack held back 0 to 5 cycles
	task automatic serveOutput(output logic stopped);
		int waitCount;
		int delay;
		waitCount = 0;
		do begin
			@(negedge clk);
			waitCount++;
			if (waitCount > `HS_TIMEOUT)
				stopOnError("timeout: no output request arrived");
		end while (!outReq && !halted);
		stopped = halted;
		if (stopped)
			return;
		if (outCount >= expWords.size())
			stopOnError("the core sent more WWD words than expected");
		checkWord("outData", outData, expWords[outCount]);
		outCount++;
		delay = int'($urandom_range(5, 0));
		repeat (delay) @(negedge clk);
		@(posedge clk);
		outAck <= 1'b1;
		waitCount = 0;
		do begin
			@(negedge clk);
			waitCount++;
			if (waitCount > `HS_TIMEOUT)
				stopOnError("timeout: outReq stayed high after the ack");
		end while (outReq);
		@(posedge clk);
		outAck <= 1'b0;
	endtask

	task automatic runMemory();
		logic stopped;
		stopped = 1'b0;
		while (!stopped)
			serveFetch(stopped);
	endtask

	task automatic runConsumer();
		logic stopped;
		stopped = 1'b0;
		while (!stopped)
			serveOutput(stopped);
	endtask

	initial begin
		int waitCount;
		void'($urandom(32'hdee));
		rstN <= 1'b0;
		imemAck <= 1'b0;
		imemData <= '0;
		outAck <= 1'b0;
		$readmemh("test/program_cases.mem", caseMem);
		progLen = caseMem[InfoBase];
		for (int i = 0; i < int'(caseMem[InfoBase + 9'd1]); i++)
			expWords.push_back(caseMem[ExpBase + 9'(i)]);

		repeat (15) @(posedge clk);
		@(negedge clk);
		checkFlag("imemReq", imemReq, 1'b0); // idle outputs under reset
		checkFlag("outReq", outReq, 1'b0);
		checkFlag("halted", halted, 1'b0);
		@(posedge clk);
		rstN <= 1'b1;

		fork
			runMemory();
			runConsumer();
		join_none

		waitCount = 0;
		do begin
			@(negedge clk);
			waitCount++;
			if (waitCount > `HS_TIMEOUT)
				stopOnError("timeout: the core never reached the halt state");
		end while (!halted);
		checkWord("WWD count", word_t'(outCount), word_t'(expWords.size()));

		for (int i = 0; i < QuietCycles; i++) begin // nothing moves after HALT
			@(negedge clk);
			checkFlag("imemReq", imemReq, 1'b0);
			checkFlag("outReq", outReq, 1'b0);
			checkFlag("halted", halted, 1'b1);
		end

		if (cpuTop_inst.cpuTop_chk_inst.failCount == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("%0d handshake or halt assertions failed",
				cpuTop_inst.cpuTop_chk_inst.failCount);
			$display("Verification failed");
			$fatal(1);
		end
	end

endmodule

/* compile.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/fetchPort.sv
verilog/controlUnit.sv
verilog/dataPath.sv
verilog/outputPort.sv
verilog/cpuTop.sv
test/cpuTop_chk.sv
test/cpuTop_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert --timing -f compile.f --top-module cpuTop_tb -o cpuSim
# assertion errors are counted by the testbench, so they must not stop the run early
./obj_dir/cpuSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -qx "Verification passed" sim.log; then
	echo "run.sh: simulation PASS"
	exit 0
fi
echo "run.sh: simulation FAIL"
exit 1

/* test/program_cases.mem */
// program image from address 0, one hex instruction word per entry
// at 100: program length, expected WWD count, then the expected WWD words in order
@000
4112 6234 5A56 43FD // r1=0012, r2=3400, r2|=0056, r3=-3
F41C F81C FC1C // wwd r1 r2 r3
5080 F01C // ori zero-extends 80
F600 F01C F901 F01C // add, sub
FB02 F01C F703 F01C // and, orr
F804 F01C F405 F01C // not, tcp
F806 F01C FC07 F01C // shl, shr
1601 F41C // beq not taken
0601 F81C // bne taken over wwd r2
1501 F81C // beq taken over wwd r2
0A01 FC1C // bne not taken
9023 F81C // jmp over wwd r2
4515 B400 F81C F81C F41C // r1=0027 then jpr r1
4002 4F01 FC1C 0CFD // r0=0, count r3 up to zero with a backward bne
F01D F81C // halt, the wwd after it never runs
@100
002E 0012
0012 3456 FFFD 0080 3468 3444 3454 FFFF
CBA9 FFEE 68AC FFFE 0012 FFFD 0027 FFFE
FFFF 0000
